/* rtl/seq_checker.sv */
`timescale 1ns/1ns

module seq_checker import uart_link_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        chk_en,
    input  logic        rx_valid,
    input  frame_byte_t rx_data,
    output frame_byte_t expected,
    output logic        mismatch
);
    logic synced;

    // first byte after enable only seeds the expected value.
    // every byte reseeds it, so one bad byte gives one mismatch.
    always_ff @(posedge clk) begin
        if (rst) begin
            synced   <= 1'b0;
            expected <= '0;
            mismatch <= 1'b0;
        end else begin
            mismatch <= 1'b0;
            if (!chk_en) begin
                synced <= 1'b0;
            end else if (rx_valid) begin
                synced   <= 1'b1;
                expected <= rx_data + 1'b1;
                mismatch <= synced && (rx_data != expected);
            end
        end
    end

endmodule

/* rtl/seq_source.sv */
`timescale 1ns/1ns

module seq_source import uart_link_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        tx_en,
    input  logic        busy,
    output logic        start,
    output frame_byte_t data
);
    localparam logic S_WAIT = 1'b0;
    localparam logic S_SEND = 1'b1;

    logic state;

    // start is held with data until the transmitter goes busy.
    // busy can only rise from our own start, so it marks acceptance.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_WAIT;
            start <= 1'b0;
            data  <= '0;
        end else begin
            case (state)
                S_WAIT: begin
                    if (busy) begin
                        // frame taken, next byte.
                        start <= 1'b0;
                        data  <= data + 1'b1;
                        state <= S_SEND;
                    end else begin
                        start <= tx_en;
                    end
                end
                default: begin
                    // frame in flight, stall until the line is free.
                    if (!busy) begin
                        start <= tx_en;
                        state <= S_WAIT;
                    end
                end
            endcase
        end
    end

endmodule

/* rtl/uart_link_consts.svh */
`ifndef UART_LINK_CONSTS_SVH
`define UART_LINK_CONSTS_SVH

// apb address width, byte offsets.
`define UART_LINK_ADDR_W 8

// register offsets.
`define REG_CTRL      8'h00
`define REG_BAUD      8'h04
`define REG_STATUS    8'h08
`define REG_RX_COUNT  8'h0C
`define REG_ERR_COUNT 8'h10
`define REG_LAST      8'h14

// bit period after reset, in clocks.
`define BIT_PERIOD_RESET 16'd16
// smaller periods leave no room for the half-bit start check.
`define BIT_PERIOD_MIN   16'd4

`endif

/* rtl/uart_link_pkg.sv */
package uart_link_pkg;

    // one uart payload byte.
    typedef logic [7:0] frame_byte_t;

    // clocks per serial bit.
    typedef logic [15:0] bit_period_t;

    // saturating event counter.
    typedef logic [15:0] event_count_t;

endpackage

/* rtl/uart_link_regs.sv */
`timescale 1ns/1ns
`include "uart_link_consts.svh"

module uart_link_regs import uart_link_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [`UART_LINK_ADDR_W-1:0] paddr,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         tx_en,
    output logic                         chk_en,
    output logic                         parity_en,
    output bit_period_t                  bit_period,
    input  logic                         rx_valid,
    input  frame_byte_t                  rx_data,
    input  frame_byte_t                  expected,
    input  logic                         mismatch,
    input  logic                         parity_err,
    input  logic                         frame_err,
    input  logic                         tx_busy
);
    logic         access;
    logic         wr;
    logic         mapped;
    logic         baud_bad;
    logic         line_err;
    logic         line_err_q;
    logic         err_event;
    logic         mismatch_s;
    logic         parity_err_s;
    logic         frame_err_s;
    event_count_t rx_count;
    event_count_t err_count;

    // access phase of a transfer, never stretched.
    assign access = psel & penable;
    assign wr     = access & pwrite;
    assign pready = access;

    // baud writes below the floor are dropped.
    assign baud_bad = pwrite && (paddr == `REG_BAUD) && (pwdata[15:0] < `BIT_PERIOD_MIN);
    assign pslverr  = access & (~mapped | baud_bad);

    // read mux, also flags unmapped offsets.
    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            `REG_CTRL:      prdata = {29'd0, parity_en, chk_en, tx_en};
            `REG_BAUD:      prdata = {16'd0, bit_period};
            `REG_STATUS:    prdata = {28'd0, tx_busy, frame_err_s, parity_err_s, mismatch_s};
            `REG_RX_COUNT:  prdata = {16'd0, rx_count};
            `REG_ERR_COUNT: prdata = {16'd0, err_count};
            `REG_LAST:      prdata = {16'd0, expected, rx_data};
            default:        mapped = 1'b0;
        endcase
    end

    // control and bit period.
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_en      <= 1'b0;
            chk_en     <= 1'b0;
            parity_en  <= 1'b0;
            bit_period <= `BIT_PERIOD_RESET;
        end else if (wr) begin
            if (paddr == `REG_CTRL) begin
                tx_en     <= pwdata[0];
                chk_en    <= pwdata[1];
                parity_en <= pwdata[2];
            end
            if ((paddr == `REG_BAUD) && !baud_bad) begin
                bit_period <= pwdata[15:0];
            end
        end
    end

    // sticky status, a new event beats a clear.
    always_ff @(posedge clk) begin
        if (rst) begin
            mismatch_s   <= 1'b0;
            parity_err_s <= 1'b0;
            frame_err_s  <= 1'b0;
        end else begin
            if (wr && (paddr == `REG_STATUS)) begin
                if (pwdata[0]) mismatch_s <= 1'b0;
                if (pwdata[1]) parity_err_s <= 1'b0;
                if (pwdata[2]) frame_err_s <= 1'b0;
            end
            if (mismatch) mismatch_s <= 1'b1;
            if (rx_valid && parity_err) parity_err_s <= 1'b1;
            if (rx_valid && frame_err) frame_err_s <= 1'b1;
        end
    end

    // line errors come with rx_valid, mismatch one cycle later.
    // a mismatch on a byte already counted as a line error is skipped.
    assign line_err  = rx_valid & (parity_err | frame_err);
    assign err_event = line_err | (mismatch & ~line_err_q);

    // saturating counters, cleared by any write.
    always_ff @(posedge clk) begin
        if (rst) begin
            line_err_q <= 1'b0;
            rx_count   <= '0;
            err_count  <= '0;
        end else begin
            line_err_q <= line_err;
            if (wr && (paddr == `REG_RX_COUNT)) begin
                rx_count <= '0;
            end else if (rx_valid && (rx_count != '1)) begin
                rx_count <= rx_count + 1'b1;
            end
            if (wr && (paddr == `REG_ERR_COUNT)) begin
                err_count <= '0;
            end else if (err_event && (err_count != '1)) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

endmodule

/* rtl/uart_link_top.sv */
`timescale 1ns/1ns
`include "uart_link_consts.svh"

module uart_link_top import uart_link_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [`UART_LINK_ADDR_W-1:0] paddr,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         tx,
    input  logic                         rx
);
    logic        tx_en;
    logic        chk_en;
    logic        parity_en;
    bit_period_t bit_period;
    logic        start;
    frame_byte_t tx_data;
    logic        tx_busy;
    logic        rx_valid;
    frame_byte_t rx_data;
    logic        parity_err;
    logic        frame_err;
    frame_byte_t expected;
    logic        mismatch;

    // register block steers both sides.
    uart_link_regs i_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .tx_en      (tx_en),
        .chk_en     (chk_en),
        .parity_en  (parity_en),
        .bit_period (bit_period),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .expected   (expected),
        .mismatch   (mismatch),
        .parity_err (parity_err),
        .frame_err  (frame_err),
        .tx_busy    (tx_busy)
    );

    // transmit side.
    seq_source i_source (
        .clk   (clk),
        .rst   (rst),
        .tx_en (tx_en),
        .busy  (tx_busy),
        .start (start),
        .data  (tx_data)
    );

    uart_tx i_tx (
        .clk        (clk),
        .rst        (rst),
        .bit_period (bit_period),
        .parity_en  (parity_en),
        .start      (start),
        .data       (tx_data),
        .tx         (tx),
        .busy       (tx_busy)
    );

    // receive side.
    uart_rx i_rx (
        .clk        (clk),
        .rst        (rst),
        .bit_period (bit_period),
        .parity_en  (parity_en),
        .rx         (rx),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .parity_err (parity_err),
        .frame_err  (frame_err)
    );

    seq_checker i_checker (
        .clk      (clk),
        .rst      (rst),
        .chk_en   (chk_en),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .expected (expected),
        .mismatch (mismatch)
    );

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx import uart_link_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  bit_period_t bit_period,
    input  logic        parity_en,
    input  logic        rx,
    output logic        rx_valid,
    output frame_byte_t rx_data,
    output logic        parity_err,
    output logic        frame_err
);
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic        rx_meta;
    logic        rx_sync;
    logic        rx_prev;
    logic [1:0]  state;
    bit_period_t period_q;
    bit_period_t clk_cnt;
    logic [3:0]  bit_idx;
    logic        par_q;
    logic        par_acc;
    logic        sample;
    logic        fall;
    frame_byte_t shift;

    // two-flop synchronizer, third flop for the edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall   = rx_prev & ~rx_sync;
    assign sample = (clk_cnt == '0);

    // receive fsm, status outputs pulse with rx_valid only.
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            par_acc    <= 1'b0;
            rx_valid   <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            rx_valid   <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
            if ((state != S_IDLE) && !sample) begin
                clk_cnt <= clk_cnt - 1'b1;
            end
            case (state)
                S_IDLE: begin
                    // wait half a bit to land mid start bit.
                    if (fall) begin
                        state   <= S_START;
                        clk_cnt <= (bit_period >> 1) - 1'b1;
                    end
                end
                S_START: begin
                    if (sample) begin
                        // glitch if the line is high again.
                        state   <= rx_sync ? S_IDLE : S_DATA;
                        clk_cnt <= period_q - 1'b1;
                        bit_idx <= '0;
                        par_acc <= 1'b0;
                    end
                end
                S_DATA: begin
                    if (sample) begin
                        // parity bit, when on, is the ninth sample.
                        par_acc <= par_acc ^ rx_sync;
                        clk_cnt <= period_q - 1'b1;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == (par_q ? 4'd8 : 4'd7)) begin
                            state <= S_STOP;
                        end
                    end
                end
                default: begin
                    if (sample) begin
                        state      <= S_IDLE;
                        rx_valid   <= 1'b1;
                        frame_err  <= ~rx_sync;
                        // even parity leaves the running xor at 0.
                        parity_err <= par_q & par_acc;
                    end
                end
            endcase
        end
    end

    // frame settings and payload.
    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && fall) begin
            period_q <= bit_period;
            par_q    <= parity_en;
        end
        if ((state == S_DATA) && sample && (bit_idx < 4'd8)) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if ((state == S_STOP) && sample) begin
            rx_data <= shift;
        end
    end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx import uart_link_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  bit_period_t bit_period,
    input  logic        parity_en,
    input  logic        start,
    input  frame_byte_t data,
    output logic        tx,
    output logic        busy
);
    bit_period_t period_q;
    bit_period_t clk_cnt;
    logic [3:0]  bits_left;
    logic [9:0]  shift;
    logic        accept;
    logic        bit_end;

    // a start seen while idle is taken at once.
    assign accept  = start & ~busy;
    assign bit_end = (clk_cnt == '0);

    // start bit goes out on acceptance.
    // bits_left counts data, parity and stop after it.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            tx        <= 1'b1;
            clk_cnt   <= '0;
            bits_left <= '0;
        end else if (accept) begin
            busy      <= 1'b1;
            tx        <= 1'b0;
            clk_cnt   <= bit_period - 1'b1;
            bits_left <= parity_en ? 4'd10 : 4'd9;
        end else if (busy) begin
            if (bit_end) begin
                if (bits_left == '0) begin
                    // stop bit done, line stays high.
                    busy <= 1'b0;
                    tx   <= 1'b1;
                end else begin
                    tx        <= shift[0];
                    bits_left <= bits_left - 1'b1;
                    clk_cnt   <= period_q - 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt - 1'b1;
            end
        end
    end

    // frame image, lsb first.
    // without parity the slot after the data is already the stop bit.
    always_ff @(posedge clk) begin
        if (accept) begin
            period_q <= bit_period;
            shift    <= {1'b1, parity_en ? ^data : 1'b1, data};
        end else if (busy && bit_end && (bits_left != '0)) begin
            shift <= {1'b1, shift[9:1]};
        end
    end

endmodule

/* tb/uart_link_assertions.sv */
`timescale 1ns/1ns

module uart_link_assertions (
    input logic        clk,
    input logic        rst,
    input logic        psel,
    input logic        penable,
    input logic        pready,
    input logic [31:0] prdata,
    input logic        pslverr,
    input logic        tx,
    input logic        tx_busy,
    input logic        tx_en,
    input logic        chk_en,
    input logic        parity_en
);

    // no wait states, and a defined response on the apb side.
    property p_no_wait_states;
        @(posedge clk) disable iff (rst)
            (psel && penable) |-> (pready && !$isunknown({prdata, pslverr}));
    endproperty

    // idle transmitter keeps the line at mark.
    property p_tx_idle_high;
        @(posedge clk) disable iff (rst)
            ($past(!tx_busy) && !tx_busy) |-> tx;
    endproperty

    // reset clears every enable.
    property p_enables_reset;
        @(posedge clk)
            rst |=> (!tx_en && !chk_en && !parity_en);
    endproperty

    a_no_wait_states: assert property (p_no_wait_states)
        else $error("pready low or undefined response in an apb access cycle");

    a_tx_idle_high: assert property (p_tx_idle_high)
        else $error("tx line low while the transmitter is idle");

    a_enables_reset: assert property (p_enables_reset)
        else $error("enables not cleared by reset");

endmodule

bind uart_link_top uart_link_assertions i_assertions (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .tx        (tx),
    .tx_busy   (tx_busy),
    .tx_en     (tx_en),
    .chk_en    (chk_en),
    .parity_en (parity_en)
);

/* tb/uart_link_tb.sv */
`timescale 1ns/1ns
`include "uart_link_consts.svh"

module uart_link_tb import uart_link_pkg::*; ();
    localparam int CLK_PERIOD = 20;

    // step kinds.
    localparam logic [3:0] OP_WR      = 4'd0;
    localparam logic [3:0] OP_RD      = 4'd1;
    localparam logic [3:0] OP_RD_MIN  = 4'd2;
    localparam logic [3:0] OP_RD_LAST = 4'd3;
    localparam logic [3:0] OP_RD_SEQ  = 4'd4;
    localparam logic [3:0] OP_SEND    = 4'd5;
    localparam logic [3:0] OP_WAIT_RX = 4'd6;
    localparam logic [3:0] OP_IDLE    = 4'd7;
    localparam logic [3:0] OP_LOOP    = 4'd8;

    // mask on a send: bit0 bad parity, bit1 low stop bit.
    typedef struct packed {
        logic [3:0]  op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] mask;
        logic [31:0] exp_val;
    } step_t;

    logic                         clk;
    logic                         rst;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [`UART_LINK_ADDR_W-1:0] paddr;
    logic [31:0]                  pwdata;
    logic [31:0]                  prdata;
    logic                         pready;
    logic                         pslverr;
    logic                         tx;
    logic                         rx;
    logic                         loop_sel;
    logic                         ser_line;
    bit_period_t                  cur_period;
    logic                         cur_parity;
    int                           rx_seen;
    integer                       seed;
    longint                       timeout_ns;
    step_t                        steps[$];

    // rx from the dut itself or from the local serializer.
    assign rx = loop_sel ? tx : ser_line;

    uart_link_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .tx      (tx),
        .rx      (rx)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // received bytes so far.
    always @(posedge clk) begin
        if (i_dut.rx_valid) begin
            rx_seen <= rx_seen + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input frame_byte_t got, input frame_byte_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count_min(input string name, input event_count_t got,
                                   input event_count_t min);
        if ($isunknown(got) || (got < min)) begin
            abort_run($sformatf("** Error: %s = 0x%h, expected at least 0x%h", name, got, min));
        end
    endtask

    function automatic string reg_name(input logic [7:0] addr);
        case (addr)
            `REG_CTRL:      return "CTRL";
            `REG_BAUD:      return "BAUD";
            `REG_STATUS:    return "STATUS";
            `REG_RX_COUNT:  return "RX_COUNT";
            `REG_ERR_COUNT: return "ERR_COUNT";
            `REG_LAST:      return "LAST";
            default:        return "unmapped";
        endcase
    endfunction

    function automatic frame_byte_t byte_plus(input frame_byte_t v, input int k);
        // wraps mod 256 on return.
        return v + k;
    endfunction

    // setup cycle, then access cycle sampled mid-cycle.
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        err = pslverr;
        // no wait states.
        check_bit("pready", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        data = prdata;
        err  = pslverr;
        check_bit("pready", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // one frame on ser_line, then wait for the dut to take it.
    task automatic send_frame(input frame_byte_t value, input logic bad_parity,
                              input logic bad_stop);
        logic [10:0] bits;
        int          n;
        int          start_count;
        start_count = rx_seen;
        // even parity, lsb first after the start bit.
        if (cur_parity) begin
            bits = {~bad_stop, (^value) ^ bad_parity, value, 1'b0};
            n    = 11;
        end else begin
            bits = {1'b1, ~bad_stop, value, 1'b0};
            n    = 10;
        end
        @(negedge clk);
        for (int i = 0; i < n; i++) begin
            ser_line = bits[i];
            repeat (cur_period) @(negedge clk);
        end
        ser_line = 1'b1;
        wait (rx_seen != start_count);
        repeat (cur_period) @(negedge clk);
    endtask

    task automatic wait_rx(input int n);
        int start_count;
        start_count = rx_seen;
        wait (rx_seen >= start_count + n);
    endtask

    task automatic idle_frames(input int n);
        repeat (n * 11 * cur_period) @(negedge clk);
    endtask

    task automatic add_step(input logic [3:0] op, input logic [7:0] addr,
                            input logic [31:0] data, input logic [31:0] mask,
                            input logic [31:0] exp_val);
        step_t s;
        s.op      = op;
        s.addr    = addr;
        s.data    = data;
        s.mask    = mask;
        s.exp_val = exp_val;
        steps.push_back(s);
    endtask

    task automatic build_steps(input frame_byte_t b);
        // register access.
        add_step(OP_RD, `REG_CTRL, 0, 32'hffff_ffff, 0);
        add_step(OP_RD, `REG_BAUD, 0, 32'hffff_ffff, `BIT_PERIOD_RESET);
        add_step(OP_WR, `REG_CTRL, 7, 0, 0);
        add_step(OP_RD, `REG_CTRL, 0, 32'hffff_ffff, 7);
        add_step(OP_WR, `REG_CTRL, 0, 0, 0);
        add_step(OP_WR, `REG_BAUD, 8, 0, 0);
        add_step(OP_RD, `REG_BAUD, 0, 32'hffff_ffff, 8);
        add_step(OP_WR, `REG_BAUD, 3, 0, 1);
        add_step(OP_RD, `REG_BAUD, 0, 32'hffff_ffff, 8);
        add_step(OP_WR, 8'h18, 0, 0, 1);
        // stray frame from the ctrl write drains first.
        add_step(OP_IDLE, 0, 2, 0, 0);
        // loopback stream.
        add_step(OP_LOOP, 0, 1, 0, 0);
        add_step(OP_WR, `REG_STATUS, 7, 0, 0);
        add_step(OP_WR, `REG_RX_COUNT, 0, 0, 0);
        add_step(OP_WR, `REG_ERR_COUNT, 0, 0, 0);
        add_step(OP_WR, `REG_CTRL, 3, 0, 0);
        add_step(OP_WAIT_RX, 0, 20, 0, 0);
        add_step(OP_RD_SEQ, `REG_LAST, 0, 0, 0);
        add_step(OP_RD, `REG_STATUS, 0, 7, 0);
        add_step(OP_RD, `REG_ERR_COUNT, 0, 32'hffff_ffff, 0);
        add_step(OP_RD_MIN, `REG_RX_COUNT, 0, 0, 18);
        // same stream with even parity.
        add_step(OP_WR, `REG_CTRL, 0, 0, 0);
        add_step(OP_IDLE, 0, 2, 0, 0);
        add_step(OP_WR, `REG_BAUD, 12, 0, 0);
        add_step(OP_WR, `REG_STATUS, 7, 0, 0);
        add_step(OP_WR, `REG_RX_COUNT, 0, 0, 0);
        add_step(OP_WR, `REG_ERR_COUNT, 0, 0, 0);
        add_step(OP_WR, `REG_CTRL, 7, 0, 0);
        add_step(OP_WAIT_RX, 0, 20, 0, 0);
        add_step(OP_RD_SEQ, `REG_LAST, 0, 0, 0);
        add_step(OP_RD, `REG_STATUS, 0, 7, 0);
        add_step(OP_RD, `REG_ERR_COUNT, 0, 32'hffff_ffff, 0);
        add_step(OP_RD_MIN, `REG_RX_COUNT, 0, 0, 18);
        // skip from b+1 to b+5 gives one mismatch.
        add_step(OP_WR, `REG_CTRL, 0, 0, 0);
        add_step(OP_IDLE, 0, 2, 0, 0);
        add_step(OP_LOOP, 0, 0, 0, 0);
        add_step(OP_WR, `REG_BAUD, 8, 0, 0);
        add_step(OP_WR, `REG_STATUS, 7, 0, 0);
        add_step(OP_WR, `REG_RX_COUNT, 0, 0, 0);
        add_step(OP_WR, `REG_ERR_COUNT, 0, 0, 0);
        add_step(OP_WR, `REG_CTRL, 2, 0, 0);
        add_step(OP_SEND, 0, b, 0, 0);
        add_step(OP_SEND, 0, byte_plus(b, 1), 0, 0);
        add_step(OP_SEND, 0, byte_plus(b, 5), 0, 0);
        add_step(OP_SEND, 0, byte_plus(b, 6), 0, 0);
        add_step(OP_RD, `REG_ERR_COUNT, 0, 32'hffff_ffff, 1);
        add_step(OP_RD, `REG_STATUS, 0, 1, 1);
        add_step(OP_RD_LAST, `REG_LAST, 0, 0, {byte_plus(b, 7), byte_plus(b, 6)});
        add_step(OP_WR, `REG_STATUS, 1, 0, 0);
        add_step(OP_RD, `REG_STATUS, 0, 1, 0);
        // line errors, still in sequence.
        // transmitter is off here, so tx_busy reads 0.
        add_step(OP_WR, `REG_CTRL, 6, 0, 0);
        add_step(OP_SEND, 0, byte_plus(b, 7), 1, 0);
        add_step(OP_SEND, 0, byte_plus(b, 8), 2, 0);
        add_step(OP_RD, `REG_STATUS, 0, 32'hffff_ffff, 6);
        add_step(OP_RD, `REG_ERR_COUNT, 0, 32'hffff_ffff, 3);
        add_step(OP_WR, `REG_ERR_COUNT, 0, 0, 0);
        add_step(OP_WR, `REG_RX_COUNT, 0, 0, 0);
        add_step(OP_RD, `REG_ERR_COUNT, 0, 32'hffff_ffff, 0);
        add_step(OP_RD, `REG_RX_COUNT, 0, 32'hffff_ffff, 0);
    endtask

    // frame time of every step at the period then in force.
    function automatic longint watchdog_limit();
        longint      clocks;
        bit_period_t period;
        clocks = 0;
        period = `BIT_PERIOD_RESET;
        foreach (steps[i]) begin
            if ((steps[i].op == OP_WR) && (steps[i].addr == `REG_BAUD) &&
                (steps[i].exp_val == 0)) begin
                period = steps[i].data[15:0];
            end
            if (steps[i].op == OP_SEND) begin
                clocks += 11 * period;
            end
            if ((steps[i].op == OP_WAIT_RX) || (steps[i].op == OP_IDLE)) begin
                clocks += steps[i].data * 11 * period;
            end
        end
        // apb transfers, reset, handshake gaps.
        clocks += steps.size() * 8 + 2000;
        return clocks * CLK_PERIOD;
    endfunction

    initial begin : watchdog
        wait (timeout_ns > 0);
        #(timeout_ns);
        abort_run($sformatf("run timed out after %0d ns", timeout_ns));
    end

    initial begin : main
        step_t       s;
        logic        err;
        logic [31:0] rd;
        frame_byte_t b;
        clk        = 1'b0;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        loop_sel   = 1'b0;
        ser_line   = 1'b1;
        rx_seen    = 0;
        cur_period = `BIT_PERIOD_RESET;
        cur_parity = 1'b0;
        seed       = 32'hb9f24877;
        b          = $random(seed);
        build_steps(b);
        timeout_ns = watchdog_limit();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            s = steps[i];
            case (s.op)
                OP_WR: begin
                    apb_write(s.addr, s.data, err);
                    check_bit({reg_name(s.addr), " pslverr"}, err, s.exp_val[0]);
                    // track what the line now runs at.
                    if (!err && (s.addr == `REG_CTRL)) begin
                        cur_parity = s.data[2];
                    end
                    if (!err && (s.addr == `REG_BAUD)) begin
                        cur_period = s.data[15:0];
                    end
                end
                OP_RD: begin
                    apb_read(s.addr, rd, err);
                    check_bit({reg_name(s.addr), " pslverr"}, err, 1'b0);
                    check_word(reg_name(s.addr), rd & s.mask, s.exp_val);
                end
                OP_RD_MIN: begin
                    apb_read(s.addr, rd, err);
                    check_bit({reg_name(s.addr), " pslverr"}, err, 1'b0);
                    check_count_min(reg_name(s.addr), rd[15:0], s.exp_val[15:0]);
                end
                OP_RD_LAST: begin
                    apb_read(s.addr, rd, err);
                    check_bit("LAST pslverr", err, 1'b0);
                    check_byte("LAST rx_data", rd[7:0], s.exp_val[7:0]);
                    check_byte("LAST expected", rd[15:8], s.exp_val[15:8]);
                end
                OP_RD_SEQ: begin
                    apb_read(s.addr, rd, err);
                    check_bit("LAST pslverr", err, 1'b0);
                    check_byte("LAST expected", rd[15:8], byte_plus(rd[7:0], 1));
                end
                OP_SEND: begin
                    send_frame(s.data[7:0], s.mask[0], s.mask[1]);
                end
                OP_WAIT_RX: begin
                    wait_rx(s.data);
                end
                OP_IDLE: begin
                    idle_frames(s.data);
                end
                default: begin
                    @(negedge clk);
                    loop_sel = s.data[0];
                end
            endcase
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* uart_link_test.f */
+incdir+rtl
rtl/uart_link_pkg.sv
rtl/uart_link_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/seq_source.sv
rtl/seq_checker.sv
rtl/uart_link_top.sv
tb/uart_link_assertions.sv
tb/uart_link_tb.sv
